// File: src.f
rename_pkg.sv
fetch_stage.sv
id_stage.sv
two_inst_buff.sv
circular_queue.sv
rat.sv
rename_dispatch.sv
rename_core.sv
rename_core_properties.sv
tb_rename_core.sv

// File: tb_rename_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rename_core;

    localparam int CLK_PERIOD  = 40;
    localparam int PHASE_PAIRS = 60;
    localparam int NUM_PHASES  = 3;
    localparam int NUM_PAIRS   = PHASE_PAIRS * NUM_PHASES;
    localparam int NUM_WORDS   = 2 * NUM_PAIRS;
    // Long enough to use up all 32 free registers
    localparam int HOLD_CYCLES = 300;

    logic                     clk;
    logic                     rst_n;
    logic [31:0]              imem_addr;
    logic [31:0]              imem_rdata;
    logic                     imem_resp;
    logic                     rs_full;
    logic                     free_valid;
    rename_pkg::preg_t        free_preg;
    logic                     dispatch_valid;
    rename_pkg::rename_pair_t dispatch_pair;

    integer      seed = 32'h061a_9686;
    logic [31:0] word_tab [NUM_WORDS];
    string       test_name [NUM_PHASES] = '{"in-order rename", "rs_full back-pressure",
                                            "retire withheld"};

    // Reference alias table, free list and commit queue
    rename_pkg::preg_t ref_rat [rename_pkg::ARCH_REGS];
    rename_pkg::preg_t free_q [$];
    rename_pkg::preg_t retire_q [$];
    rename_pkg::preg_t ret_reg;

    int   pairs_done;
    int   checks;
    int   errors;
    int   phase_errors_base;
    int   hold_left;
    logic rs_full_seen;
    logic drained;

    rename_core DUT (
        .clk(clk), .rst_n(rst_n),
        .imem_addr(imem_addr), .imem_rdata(imem_rdata), .imem_resp(imem_resp),
        .rs_full(rs_full), .free_valid(free_valid), .free_preg(free_preg),
        .dispatch_valid(dispatch_valid), .dispatch_pair(dispatch_pair)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic int unsigned rand_below(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    // One legal RV32I word with registers in x0..x7 for lots of dependences
    function automatic logic [31:0] make_inst();
        logic [31:0] r;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [31:0] w;
        r   = $random(seed);
        rd  = 5'(rand_below(8));
        rs1 = 5'(rand_below(8));
        rs2 = 5'(rand_below(8));
        f3  = 3'(rand_below(8));
        case (rand_below(9))
            0: w = {r[31:12], rd, rename_pkg::OPC_LUI};
            1: w = {r[31:12], rd, rename_pkg::OPC_AUIPC};
            2: w = {r[31:12], rd, rename_pkg::OPC_JAL};
            3: w = {r[31:20], rs1, 3'b000, rd, rename_pkg::OPC_JALR};
            4: begin
                // 010 and 011 are not branches
                if (f3[2:1] == 2'b01) f3[2] = 1'b1;
                w = {r[31:25], rs2, rs1, f3, r[11:7], rename_pkg::OPC_BRANCH};
            end
            5: begin
                if (f3 == 3'd3 || f3 > 3'd5) f3 = 3'd2;
                w = {r[31:20], rs1, f3, rd, rename_pkg::OPC_LOAD};
            end
            6: begin
                if (f3 > 3'd2) f3 = 3'd2;
                w = {r[31:25], rs2, rs1, f3, r[11:7], rename_pkg::OPC_STORE};
            end
            7: begin
                // Shift immediates keep funct7 clear
                if (f3[1:0] == 2'b01) w = {7'b0, r[24:20], rs1, f3, rd, rename_pkg::OPC_OP_IMM};
                else w = {r[31:20], rs1, f3, rd, rename_pkg::OPC_OP_IMM};
            end
            default: w = {7'b0, rs2, rs1, f3, rd, rename_pkg::OPC_OP};
        endcase
        return w;
    endfunction

    // Register use straight from the ISA opcode classes
    function automatic rename_pkg::decoded_inst_t ref_decode(input logic [31:0] w, input int idx);
        rename_pkg::decoded_inst_t d;
        logic [6:0]                op;
        logic                      rd_op;
        op          = w[6:0];
        d.pc        = 32'(idx * 4);
        d.opcode    = op;
        d.rs1       = w[19:15];
        d.rs2       = w[24:20];
        d.rd        = w[11:7];
        rd_op       = op inside {rename_pkg::OPC_LUI, rename_pkg::OPC_AUIPC, rename_pkg::OPC_JAL,
                                 rename_pkg::OPC_JALR, rename_pkg::OPC_LOAD,
                                 rename_pkg::OPC_OP_IMM, rename_pkg::OPC_OP};
        d.uses_rs1  = op inside {rename_pkg::OPC_JALR, rename_pkg::OPC_BRANCH,
                                 rename_pkg::OPC_LOAD, rename_pkg::OPC_STORE,
                                 rename_pkg::OPC_OP_IMM, rename_pkg::OPC_OP};
        d.uses_rs2  = op inside {rename_pkg::OPC_BRANCH, rename_pkg::OPC_STORE, rename_pkg::OPC_OP};
        d.writes_rd = rd_op && (d.rd != 5'd0);
        return d;
    endfunction

    task automatic check_value(input string what, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0d ns: %s got 0x%0h expected 0x%0h", $time, what, got, exp);
        end
    endtask

    // Lanes go in order so lane 1 sees lane 0's update without a bypass rule
    task automatic check_pair(input rename_pkg::rename_pair_t got);
        rename_pkg::decoded_inst_t d;
        rename_pkg::renamed_inst_t e;
        int                        idx;
        for (int l = 0; l < rename_pkg::SS; l++) begin
            idx         = 2 * pairs_done + l;
            d           = ref_decode(word_tab[idx], idx);
            e.pc        = d.pc;
            e.opcode    = d.opcode;
            e.writes_rd = d.writes_rd;
            e.prs1      = d.uses_rs1 ? ref_rat[d.rs1] : '0;
            e.prs2      = d.uses_rs2 ? ref_rat[d.rs2] : '0;
            e.prd       = '0;
            e.old_prd   = '0;
            if (d.writes_rd) begin
                if (free_q.size() == 0) begin
                    errors++;
                    $display("Pair %0d lane %0d was dispatched with no free register left",
                             pairs_done, l);
                end else begin
                    e.prd = free_q.pop_front();
                end
                e.old_prd     = ref_rat[d.rd];
                ref_rat[d.rd] = e.prd;
                retire_q.push_back(e.old_prd);
            end
            check_value($sformatf("pair %0d lane %0d", pairs_done, l), got[l], e);
            check_value($sformatf("pair %0d lane %0d prd is p0", pairs_done, l),
                        got[l].writes_rd && (got[l].prd == '0), 0);
        end
    endtask

    // Output checks come before the next input values
    always @(posedge clk) begin
        if (rst_n) begin
            if (rs_full_seen) check_value("dispatch_valid after rs_full", dispatch_valid, 0);
            if (dispatch_valid) begin
                if (pairs_done >= NUM_PAIRS) begin
                    errors++;
                    $display("A pair was dispatched after the last one in the stream");
                end else begin
                    check_pair(dispatch_pair);
                    pairs_done++;
                    if (pairs_done % PHASE_PAIRS == 0) begin
                        $display("test %0d %s: %0d pairs, %0d errors",
                                 pairs_done / PHASE_PAIRS, test_name[pairs_done / PHASE_PAIRS - 1],
                                 PHASE_PAIRS, errors - phase_errors_base);
                        phase_errors_base = errors;
                        if (pairs_done == 2 * PHASE_PAIRS) hold_left = HOLD_CYCLES;
                    end
                end
            end
            rs_full_seen = rs_full;

            // Free list should be empty by the end of the hold
            if (hold_left > 0) begin
                hold_left--;
                if (hold_left == 0) drained = (free_q.size() < rename_pkg::SS);
            end

            // Memory answers at most every other cycle so the address is settled
            if (!imem_resp && (imem_addr < 4 * NUM_WORDS) && (rand_below(2) == 0)) begin
                imem_resp  <= 1'b1;
                imem_rdata <= word_tab[imem_addr[31:2]];
            end else begin
                imem_resp <= 1'b0;
            end

            rs_full <= (pairs_done / PHASE_PAIRS == 1) && (rand_below(2) == 1);

            // Commit returns old registers in dispatch order
            free_valid <= 1'b0;
            if ((hold_left == 0) && (retire_q.size() > 0) && (rand_below(2) == 0)) begin
                ret_reg = retire_q.pop_front();
                free_q.push_back(ret_reg);
                free_valid <= 1'b1;
                free_preg  <= ret_reg;
            end
        end
    end

    initial begin
        rst_n             = 1'b0;
        imem_rdata        = '0;
        imem_resp         = 1'b0;
        rs_full           = 1'b0;
        free_valid        = 1'b0;
        free_preg         = '0;
        pairs_done        = 0;
        checks            = 0;
        errors            = 0;
        phase_errors_base = 0;
        hold_left         = 0;
        rs_full_seen      = 1'b0;
        drained           = 1'b0;
        for (int i = 0; i < NUM_WORDS; i++) word_tab[i] = make_inst();
        for (int r = 0; r < rename_pkg::ARCH_REGS; r++) ref_rat[r] = rename_pkg::preg_t'(r);
        for (int p = rename_pkg::ARCH_REGS; p < rename_pkg::PR_ENTRIES; p++) begin
            free_q.push_back(rename_pkg::preg_t'(p));
        end
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        wait (pairs_done == NUM_PAIRS);
        // Window for any stray extra dispatch
        repeat (20) @(posedge clk);
        check_value("free list drained during retire hold", drained, 1);
        // Fetch stops right after the last word of the stream
        check_value("imem_addr at end of stream", imem_addr, 4 * NUM_WORDS);
        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin
        #(NUM_PAIRS * 40 * CLK_PERIOD);
        $display("Timed out with %0d of %0d pairs dispatched", pairs_done, NUM_PAIRS);
        $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: rename_core_properties.sv
`timescale 1ns/1ps
`default_nettype none

module rename_core_properties (
    input logic        clk,
    input logic        rst_n,
    input logic        imem_resp,
    input logic        iq_full,
    input logic [31:0] imem_addr,
    input logic        rs_full,
    input logic        dispatch_valid
);

    logic accept;

    // Word taken when memory answers and the queue has room
    assign accept = imem_resp && !iq_full;

    // Quiet first cycle out of reset
    a_reset_quiet: assert property (@(posedge clk) $rose(rst_n) |-> !dispatch_valid)
        else $error("dispatch_valid high in the first cycle after reset");

    // rs_full blocks the pop, so no strobe one cycle later
    a_rs_full_stall: assert property (@(posedge clk) disable iff (!rst_n)
        rs_full |=> !dispatch_valid)
        else $error("dispatch in the cycle after rs_full was high");

    a_pc_step: assert property (@(posedge clk) disable iff (!rst_n)
        accept |=> imem_addr == $past(imem_addr) + 32'd4)
        else $error("imem_addr did not advance by 4 after an acceptance");

    a_pc_hold: assert property (@(posedge clk) disable iff (!rst_n)
        !accept |=> $stable(imem_addr))
        else $error("imem_addr moved without an acceptance");

endmodule

bind rename_core rename_core_properties u_props (
    .clk(clk), .rst_n(rst_n), .imem_resp(imem_resp), .iq_full(iq_full),
    .imem_addr(imem_addr), .rs_full(rs_full), .dispatch_valid(dispatch_valid)
);

`default_nettype wire

// File: rename_core.sv
`timescale 1ns/1ps
`default_nettype none

module rename_core (
    input  logic                     clk,
    input  logic                     rst_n,
    output logic [31:0]              imem_addr,
    input  logic [31:0]              imem_rdata,
    input  logic                     imem_resp,
    input  logic                     rs_full,
    input  logic                     free_valid,
    input  rename_pkg::preg_t        free_preg,
    output logic                     dispatch_valid,
    output rename_pkg::rename_pair_t dispatch_pair
);

    rename_pkg::fetch_output_t                fetch_out;
    rename_pkg::decoded_inst_t                decoded;
    logic                                     decoded_valid;
    rename_pkg::inst_pair_t                   pair;
    logic                                     pair_valid;
    logic                                     iq_full;
    rename_pkg::inst_pair_t                   iq_head;
    rename_pkg::iq_cnt_t                      iq_count;
    rename_pkg::lane_cnt_t                    pop_inst_q;
    rename_pkg::preg_t [rename_pkg::SS-1:0]   fl_head;
    rename_pkg::fl_cnt_t                      fl_count;
    rename_pkg::lane_cnt_t                    pop_free_list;
    rename_pkg::areg_t [rename_pkg::SS-1:0]   isa_rs1;
    rename_pkg::areg_t [rename_pkg::SS-1:0]   isa_rs2;
    rename_pkg::areg_t [rename_pkg::SS-1:0]   isa_rd;
    rename_pkg::preg_t [rename_pkg::SS-1:0]   rat_rs1;
    rename_pkg::preg_t [rename_pkg::SS-1:0]   rat_rs2;
    rename_pkg::preg_t [rename_pkg::SS-1:0]   rat_rd;
    rename_pkg::preg_t [rename_pkg::SS-1:0]   old_rd;
    logic [rename_pkg::SS-1:0]                modify_rat;

    fetch_stage u_fetch (
        .clk(clk), .rst_n(rst_n),
        .imem_rdata(imem_rdata), .imem_resp(imem_resp),
        .stall_inst(iq_full),
        .imem_addr(imem_addr), .fetch_output(fetch_out)
    );

    id_stage u_decode (
        .fetch_output(fetch_out),
        .instruction_info(decoded), .inst_valid(decoded_valid)
    );

    two_inst_buff u_pair (
        .clk(clk), .rst_n(rst_n),
        .valid(decoded_valid), .decoded_inst(decoded),
        .valid_inst(pair), .valid_out(pair_valid)
    );

    // Instruction queue takes a whole pair per push
    circular_queue #(
        .T(rename_pkg::decoded_inst_t), .DEPTH(rename_pkg::IQ_DEPTH)
    ) u_inst_q (
        .clk(clk), .rst_n(rst_n),
        .in(pair), .push_cnt({pair_valid, 1'b0}),
        .pop_cnt(pop_inst_q),
        .out(iq_head), .count(iq_count), .full(iq_full)
    );

    // Free list starts with p32 to p63 and takes one retired register per cycle
    circular_queue #(
        .T(rename_pkg::preg_t), .DEPTH(rename_pkg::FREE_DEPTH),
        .FILL_ON_RESET(1'b1), .FILL_BASE(rename_pkg::ARCH_REGS)
    ) u_free_list (
        .clk(clk), .rst_n(rst_n),
        .in({free_preg, free_preg}), .push_cnt({1'b0, free_valid}),
        .pop_cnt(pop_free_list),
        .out(fl_head), .count(fl_count), .full()
    );

    rat u_rat (
        .clk(clk), .rst_n(rst_n),
        .isa_rs1(isa_rs1), .isa_rs2(isa_rs2),
        .rat_rs1(rat_rs1), .rat_rs2(rat_rs2),
        .isa_rd(isa_rd), .rat_rd(rat_rd), .regf_we(modify_rat),
        .old_rd(old_rd)
    );

    rename_dispatch u_rename (
        .clk(clk), .rst_n(rst_n),
        .instruction(iq_head), .inst_q_count(iq_count),
        .free_list_regs(fl_head), .free_count(fl_count),
        .rs_full(rs_full),
        .rat_rs1(rat_rs1), .rat_rs2(rat_rs2), .old_rd(old_rd),
        .isa_rs1(isa_rs1), .isa_rs2(isa_rs2), .isa_rd(isa_rd),
        .rat_rd(rat_rd), .modify_rat(modify_rat),
        .pop_inst_q(pop_inst_q), .pop_free_list(pop_free_list),
        .dispatch_valid(dispatch_valid), .dispatch_pair(dispatch_pair)
    );

endmodule

`default_nettype wire

// File: rename_dispatch.sv
`timescale 1ns/1ps
`default_nettype none

module rename_dispatch (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  rename_pkg::inst_pair_t                 instruction,
    input  rename_pkg::iq_cnt_t                    inst_q_count,
    input  rename_pkg::preg_t [rename_pkg::SS-1:0] free_list_regs,
    input  rename_pkg::fl_cnt_t                    free_count,
    input  logic                                   rs_full,
    input  rename_pkg::preg_t [rename_pkg::SS-1:0] rat_rs1,
    input  rename_pkg::preg_t [rename_pkg::SS-1:0] rat_rs2,
    input  rename_pkg::preg_t [rename_pkg::SS-1:0] old_rd,
    output rename_pkg::areg_t [rename_pkg::SS-1:0] isa_rs1,
    output rename_pkg::areg_t [rename_pkg::SS-1:0] isa_rs2,
    output rename_pkg::areg_t [rename_pkg::SS-1:0] isa_rd,
    output rename_pkg::preg_t [rename_pkg::SS-1:0] rat_rd,
    output logic [rename_pkg::SS-1:0]              modify_rat,
    output rename_pkg::lane_cnt_t                  pop_inst_q,
    output rename_pkg::lane_cnt_t                  pop_free_list,
    output logic                                   dispatch_valid,
    output rename_pkg::rename_pair_t               dispatch_pair
);

    logic [rename_pkg::SS-1:0] wr;
    rename_pkg::lane_cnt_t     need;
    logic                      take;
    rename_pkg::rename_pair_t  renamed;

    // Architectural fields straight to the RAT
    always_comb begin
        for (int i = 0; i < rename_pkg::SS; i++) begin
            isa_rs1[i] = instruction[i].rs1;
            isa_rs2[i] = instruction[i].rs2;
            isa_rd[i]  = instruction[i].rd;
            wr[i]      = instruction[i].writes_rd;
        end
    end

    // Free registers needed by this pair
    assign need = rename_pkg::lane_cnt_t'(wr[0]) + rename_pkg::lane_cnt_t'(wr[1]);

    // Full pair, enough free registers, room downstream
    assign take = (inst_q_count >= rename_pkg::SS) && (free_count >= need) && !rs_full;

    assign pop_inst_q    = take ? rename_pkg::lane_cnt_t'(rename_pkg::SS) : '0;
    assign pop_free_list = take ? need : '0;

    // Free list order, lane 0 first
    assign rat_rd[0] = free_list_regs[0];
    assign rat_rd[1] = wr[0] ? free_list_regs[1] : free_list_regs[0];

    assign modify_rat = take ? wr : '0;

    always_comb begin
        for (int i = 0; i < rename_pkg::SS; i++) begin
            renamed[i].pc        = instruction[i].pc;
            renamed[i].opcode    = instruction[i].opcode;
            renamed[i].writes_rd = wr[i];
            renamed[i].prd       = wr[i] ? rat_rd[i] : '0;
            renamed[i].old_prd   = wr[i] ? old_rd[i] : '0;
            // Unused sources read p0
            renamed[i].prs1      = instruction[i].uses_rs1 ? rat_rs1[i] : '0;
            renamed[i].prs2      = instruction[i].uses_rs2 ? rat_rs2[i] : '0;
        end

        // Lane 1 sees lane 0's write before the RAT does
        if (wr[0]) begin
            if (instruction[1].uses_rs1 && (instruction[1].rs1 == instruction[0].rd)) begin
                renamed[1].prs1 = rat_rd[0];
            end
            if (instruction[1].uses_rs2 && (instruction[1].rs2 == instruction[0].rd)) begin
                renamed[1].prs2 = rat_rd[0];
            end
            // Same destination, lane 1 frees lane 0's new register
            if (wr[1] && (instruction[1].rd == instruction[0].rd)) begin
                renamed[1].old_prd = rat_rd[0];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dispatch_valid <= 1'b0;
        end else begin
            dispatch_valid <= take;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            dispatch_pair <= renamed;
        end
    end

endmodule

`default_nettype wire

// File: rat.sv
`timescale 1ns/1ps
`default_nettype none

module rat (
    input  logic                                clk,
    input  logic                                rst_n,
    input  rename_pkg::areg_t [rename_pkg::SS-1:0] isa_rs1,
    input  rename_pkg::areg_t [rename_pkg::SS-1:0] isa_rs2,
    output rename_pkg::preg_t [rename_pkg::SS-1:0] rat_rs1,
    output rename_pkg::preg_t [rename_pkg::SS-1:0] rat_rs2,
    input  rename_pkg::areg_t [rename_pkg::SS-1:0] isa_rd,
    input  rename_pkg::preg_t [rename_pkg::SS-1:0] rat_rd,
    input  logic [rename_pkg::SS-1:0]              regf_we,
    output rename_pkg::preg_t [rename_pkg::SS-1:0] old_rd
);

    rename_pkg::preg_t map [rename_pkg::ARCH_REGS];

    // Identity mapping out of reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int r = 0; r < rename_pkg::ARCH_REGS; r++) begin
                map[r] <= rename_pkg::preg_t'(r);
            end
        end else begin
            // Later lane overwrites, so lane 1 wins a same-register clash
            for (int i = 0; i < rename_pkg::SS; i++) begin
                if (regf_we[i] && (isa_rd[i] != '0)) begin
                    map[isa_rd[i]] <= rat_rd[i];
                end
            end
        end
    end

    // Reads see the map before this cycle's writes
    always_comb begin
        for (int i = 0; i < rename_pkg::SS; i++) begin
            rat_rs1[i] = map[isa_rs1[i]];
            rat_rs2[i] = map[isa_rs2[i]];
            old_rd[i]  = map[isa_rd[i]];
        end
    end

endmodule

`default_nettype wire

// File: circular_queue.sv
`timescale 1ns/1ps
`default_nettype none

module circular_queue #(
    parameter type T             = rename_pkg::preg_t,
    parameter int  DEPTH         = rename_pkg::IQ_DEPTH,
    parameter bit  FILL_ON_RESET = 1'b0,
    parameter int  FILL_BASE     = 0
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  T [rename_pkg::SS-1:0]           in,
    input  rename_pkg::lane_cnt_t           push_cnt,
    input  rename_pkg::lane_cnt_t           pop_cnt,
    output T [rename_pkg::SS-1:0]           out,
    output logic [$clog2(DEPTH+1)-1:0]      count,
    output logic                            full
);

    // DEPTH is a power of two so pointers wrap on their own
    typedef logic [$clog2(DEPTH)-1:0] ptr_t;

    T     mem [DEPTH];
    ptr_t head;
    ptr_t tail;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head  <= '0;
            tail  <= '0;
            // Filled queue starts with every slot occupied
            count <= FILL_ON_RESET ? ($clog2(DEPTH+1))'(DEPTH) : '0;
        end else begin
            head  <= head + ptr_t'(pop_cnt);
            tail  <= tail + ptr_t'(push_cnt);
            count <= count + push_cnt - pop_cnt;
        end
    end

    generate
        if (FILL_ON_RESET) begin : g_fill
            // Slot i starts out holding FILL_BASE + i
            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    for (int i = 0; i < DEPTH; i++) begin
                        mem[i] <= T'(FILL_BASE + i);
                    end
                end else begin
                    for (int i = 0; i < rename_pkg::SS; i++) begin
                        if (i < push_cnt) begin
                            mem[tail + ptr_t'(i)] <= in[i];
                        end
                    end
                end
            end
        end else begin : g_plain
            always_ff @(posedge clk) begin
                for (int i = 0; i < rename_pkg::SS; i++) begin
                    if (i < push_cnt) begin
                        mem[tail + ptr_t'(i)] <= in[i];
                    end
                end
            end
        end
    endgenerate

    // Head entries, oldest in lane 0
    always_comb begin
        for (int i = 0; i < rename_pkg::SS; i++) begin
            out[i] = mem[head + ptr_t'(i)];
        end
    end

    // Two pairs of headroom covers the pair still in flight
    assign full = (DEPTH - int'(count)) < 2 * rename_pkg::SS;

endmodule

`default_nettype wire

// File: two_inst_buff.sv
`timescale 1ns/1ps
`default_nettype none

module two_inst_buff (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      valid,
    input  rename_pkg::decoded_inst_t decoded_inst,
    output rename_pkg::inst_pair_t    valid_inst,
    output logic                      valid_out
);

    logic                      half;
    rename_pkg::decoded_inst_t lane0;

    // Half flag toggles on every decoded instruction
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            half <= 1'b0;
        end else if (valid) begin
            half <= !half;
        end
    end

    // Older instruction waits here for its partner
    always_ff @(posedge clk) begin
        if (valid && !half) begin
            lane0 <= decoded_inst;
        end
    end

    // Pair goes out in the cycle the second one shows up
    always_comb begin
        valid_inst[0] = lane0;
        valid_inst[1] = decoded_inst;
    end

    assign valid_out = valid && half;

endmodule

`default_nettype wire

// File: id_stage.sv
`timescale 1ns/1ps
`default_nettype none

module id_stage (
    input  rename_pkg::fetch_output_t fetch_output,
    output rename_pkg::decoded_inst_t instruction_info,
    output logic                      inst_valid
);

    logic [31:0] inst;
    logic [6:0]  opcode;
    logic        rd_class;

    assign inst   = fetch_output.inst;
    assign opcode = inst[6:0];

    always_comb begin
        instruction_info.pc     = fetch_output.pc;
        instruction_info.opcode = opcode;
        // Standard R/I/S/B field positions
        instruction_info.rs1    = inst[19:15];
        instruction_info.rs2    = inst[24:20];
        instruction_info.rd     = inst[11:7];

        rd_class                  = 1'b0;
        instruction_info.uses_rs1 = 1'b0;
        instruction_info.uses_rs2 = 1'b0;
        unique case (opcode)
            rename_pkg::OPC_LUI,
            rename_pkg::OPC_AUIPC,
            rename_pkg::OPC_JAL: begin
                rd_class = 1'b1;
            end
            rename_pkg::OPC_JALR,
            rename_pkg::OPC_LOAD,
            rename_pkg::OPC_OP_IMM: begin
                rd_class                  = 1'b1;
                instruction_info.uses_rs1 = 1'b1;
            end
            rename_pkg::OPC_BRANCH,
            rename_pkg::OPC_STORE: begin
                instruction_info.uses_rs1 = 1'b1;
                instruction_info.uses_rs2 = 1'b1;
            end
            rename_pkg::OPC_OP: begin
                rd_class                  = 1'b1;
                instruction_info.uses_rs1 = 1'b1;
                instruction_info.uses_rs2 = 1'b1;
            end
            default: ;
        endcase

        // Writes to x0 are dropped so they never take a physical register
        instruction_info.writes_rd = rd_class && (inst[11:7] != '0);
    end

    assign inst_valid = fetch_output.valid;

endmodule

`default_nettype wire

// File: fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_stage (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [31:0]               imem_rdata,
    input  logic                      imem_resp,
    input  logic                      stall_inst,
    output logic [31:0]               imem_addr,
    output rename_pkg::fetch_output_t fetch_output
);

    logic [31:0] pc;
    logic        out_valid;
    logic [31:0] out_pc;
    logic [31:0] out_inst;
    logic        accept;

    // Word taken only while the instruction queue has room
    assign accept = imem_resp && !stall_inst;

    // Sequential fetch, no redirects
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc        <= '0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= accept;
            if (accept) begin
                pc <= pc + 32'd4;
            end
        end
    end

    // Word and its PC
    always_ff @(posedge clk) begin
        if (accept) begin
            out_pc   <= pc;
            out_inst <= imem_rdata;
        end
    end

    assign imem_addr    = pc;
    assign fetch_output = '{valid: out_valid, pc: out_pc, inst: out_inst};

endmodule

`default_nettype wire

// File: rename_pkg.sv
`default_nettype none

package rename_pkg;

    // Front end is built for a two-wide machine only
    localparam int SS         = 2;
    localparam int ARCH_REGS  = 32;
    localparam int PR_ENTRIES = 64;
    localparam int FREE_DEPTH = 32;
    localparam int IQ_DEPTH   = 8;

    // RV32I major opcodes
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    typedef logic [$clog2(PR_ENTRIES)-1:0] preg_t;
    typedef logic [$clog2(ARCH_REGS)-1:0]  areg_t;

    // Queue occupancy and per-cycle lane counts
    typedef logic [$clog2(IQ_DEPTH+1)-1:0]   iq_cnt_t;
    typedef logic [$clog2(FREE_DEPTH+1)-1:0] fl_cnt_t;
    typedef logic [$clog2(SS+1)-1:0]         lane_cnt_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] inst;
    } fetch_output_t;

    // Decode rules
    // writes_rd for LUI, AUIPC, JAL, JALR, LOAD, OP-IMM and OP with rd not x0
    // uses_rs1 for JALR, BRANCH, LOAD, STORE, OP-IMM and OP
    // uses_rs2 for BRANCH, STORE and OP
    // An unused source renames to physical register 0
    typedef struct packed {
        logic [31:0] pc;
        logic [6:0]  opcode;
        areg_t       rs1;
        areg_t       rs2;
        areg_t       rd;
        logic        uses_rs1;
        logic        uses_rs2;
        logic        writes_rd;
    } decoded_inst_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [6:0]  opcode;
        preg_t       prs1;
        preg_t       prs2;
        preg_t       prd;
        preg_t       old_prd;
        logic        writes_rd;
    } renamed_inst_t;

    // Lane 0 is the older instruction
    typedef decoded_inst_t [SS-1:0] inst_pair_t;
    typedef renamed_inst_t [SS-1:0] rename_pair_t;

endpackage

`default_nettype wire
